// File: source/rv_pkg.sv
package rv_pkg;

  // machine word and register index
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes of the supported subset
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_environ = 7'b1110011;

  // funct7 of the base ops, and of sub / sra / srai
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // funct3 for the integer ops
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for the conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu
  } br_op_e;

endpackage

// File: source/alu.sv
`timescale 1ns/1ns

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::br_op_e  br_op,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal       = (a == b);

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {31'd0, lt_signed};
      alu_sltu:   result = {31'd0, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // comparison for the branch, independent of the result mux
  always_comb begin
    case (br_op)
      beq:     branch_taken = equal;
      bne:     branch_taken = !equal;
      blt:     branch_taken = lt_signed;
      bge:     branch_taken = !lt_signed;
      bltu:    branch_taken = lt_unsigned;
      bgeu:    branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: source/insn_decode.sv
`timescale 1ns/1ns

module insn_decode (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output logic              use_imm,
  output logic              use_pc,
  output rv_pkg::alu_op_e   alu_op,
  output logic              is_branch,
  output rv_pkg::br_op_e    br_op,
  output logic              rd_we,
  output logic              ecall,
  output logic              illegal
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;

  word_t      imm_i;
  word_t      imm_sh;
  word_t      imm_b;
  word_t      imm_u;

  logic       we_raw;
  logic       branch_raw;
  logic       ecall_raw;
  logic       bad;

  // shared by the reg-imm and reg-reg groups
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode  = insn[6:0];
  assign rd      = insn[11:7];
  assign funct3  = insn[14:12];
  assign rs1     = insn[19:15];
  assign rs2     = insn[24:20];
  assign funct7  = insn[31:25];
  assign f7_base = (funct7 == funct7_base);
  assign f7_alt  = (funct7 == funct7_alt);

  assign imm_i  = {{20{insn[31]}}, insn[31:20]};
  assign imm_sh = {27'd0, insn[24:20]};
  assign imm_b  = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u  = {insn[31:12], 12'd0};

  always_comb begin
    imm        = imm_i;
    use_imm    = 1'b0;
    use_pc     = 1'b0;
    alu_op     = alu_add;
    br_op      = beq;
    we_raw     = 1'b0;
    branch_raw = 1'b0;
    ecall_raw  = 1'b0;
    bad        = 1'b0;
    case (opcode)
      op_lui: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
        we_raw  = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        we_raw  = 1'b1;
      end
      op_reg_imm: begin
        use_imm = 1'b1;
        we_raw  = 1'b1;
        // only the shifts look at funct7, the rest is immediate
        alu_op  = arith_op(funct3, f7_alt && funct3 == f3_sr);
        if (funct3 == f3_sll || funct3 == f3_sr) begin
          imm = imm_sh;
          bad = !(f7_base || (f7_alt && funct3 == f3_sr));
        end
      end
      op_reg_reg: begin
        we_raw = 1'b1;
        alu_op = arith_op(funct3, f7_alt);
        bad    = !(f7_base || (f7_alt && (funct3 == f3_add || funct3 == f3_sr)));
      end
      op_branch: begin
        imm        = imm_b;
        branch_raw = 1'b1;
        case (funct3)
          f3_beq:  br_op = beq;
          f3_bne:  br_op = bne;
          f3_blt:  br_op = blt;
          f3_bge:  br_op = bge;
          f3_bltu: br_op = bltu;
          f3_bgeu: br_op = bgeu;
          default: bad = 1'b1;
        endcase
      end
      op_environ: begin
        // ecall only, every other system op is rejected
        if (insn[31:7] == 25'd0) begin
          ecall_raw = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
  end

  assign rd_we     = we_raw & ~bad;
  assign is_branch = branch_raw & ~bad;
  assign ecall     = ecall_raw;
  assign illegal   = bad;

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ns

module pc_unit #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          is_branch,
  input  logic          branch_taken,
  input  rv_pkg::word_t branch_off,
  input  logic          ecall,
  output rv_pkg::word_t pc,
  output logic          halt
);
  import rv_pkg::*;

  word_t pc_seq;
  word_t pc_target;
  word_t next_pc;

  assign pc_seq    = pc + word_t'(4);
  assign pc_target = pc + branch_off;
  assign next_pc   = (is_branch && branch_taken) ? pc_target : pc_seq;

  // halt is sticky until the next reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      if (ecall) begin
        // pc stays on the ecall
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  input  rv_pkg::reg_addr_t raddr_a,
  input  rv_pkg::reg_addr_t raddr_b,
  output rv_pkg::word_t     rdata_a,
  output rv_pkg::word_t     rdata_b
);
  import rv_pkg::*;

  localparam int num_regs = 2 ** reg_addr_w;

  word_t regs [num_regs];

  // x0 is never written, so it reads as zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads, no write bypass
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     insn,
  output rv_pkg::word_t     pc,
  output logic              halt,
  output logic              illegal,
  output logic              wb_en,
  output rv_pkg::reg_addr_t wb_addr,
  output rv_pkg::word_t     wb_data
);
  import rv_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  logic      use_imm;
  logic      use_pc;
  alu_op_e   alu_op;
  logic      is_branch;
  br_op_e    br_op;
  logic      rd_we;
  logic      ecall;
  logic      dec_illegal;

  word_t     rdata_a;
  word_t     rdata_b;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  logic      branch_taken;

  insn_decode u_decode (
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .alu_op    (alu_op),
    .is_branch (is_branch),
    .br_op     (br_op),
    .rd_we     (rd_we),
    .ecall     (ecall),
    .illegal   (dec_illegal)
  );

  // nothing retires while halted or in reset
  assign wb_en   = rd_we & ~halt & ~rst;
  assign wb_addr = rd;
  assign wb_data = alu_result;
  assign illegal = dec_illegal & ~halt;

  reg_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .we      (wb_en),
    .waddr   (wb_addr),
    .wdata   (wb_data),
    .raddr_a (rs1),
    .raddr_b (rs2),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  // auipc takes pc as operand a
  assign alu_a = use_pc ? pc : rdata_a;
  assign alu_b = use_imm ? imm : rdata_b;

  alu u_alu (
    .a            (alu_a),
    .b            (alu_b),
    .op           (alu_op),
    .br_op        (br_op),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  pc_unit #(
    .reset_pc (reset_pc)
  ) u_pc (
    .clk          (clk),
    .rst          (rst),
    .is_branch    (is_branch),
    .branch_taken (branch_taken),
    .branch_off   (imm),
    .ecall        (ecall),
    .pc           (pc),
    .halt         (halt)
  );

endmodule

// File: include/rv_asm.svh
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

// register-immediate op, imm is the raw 12-bit field
function automatic rv_pkg::word_t enc_i(input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
                                        input rv_pkg::reg_addr_t rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, rv_pkg::op_reg_imm};
endfunction

// slli / srli / srai carry funct7 in the upper immediate bits
function automatic rv_pkg::word_t enc_sh(input logic [6:0] f7, input logic [2:0] f3,
                                         input rv_pkg::reg_addr_t rd,
                                         input rv_pkg::reg_addr_t rs1, input logic [4:0] shamt);
  return {f7, shamt, rs1, f3, rd, rv_pkg::op_reg_imm};
endfunction

function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input rv_pkg::reg_addr_t rd,
                                        input rv_pkg::reg_addr_t rs1,
                                        input rv_pkg::reg_addr_t rs2);
  return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
endfunction

// lui or auipc, imm20 lands in bits 31:12
function automatic rv_pkg::word_t enc_u(input logic [6:0] op, input rv_pkg::reg_addr_t rd,
                                        input logic [19:0] imm20);
  return {imm20, rd, op};
endfunction

// byte offset, bit 0 is dropped
function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input rv_pkg::reg_addr_t rs1,
                                        input rv_pkg::reg_addr_t rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
endfunction

function automatic rv_pkg::word_t enc_ecall();
  return {25'd0, rv_pkg::op_environ};
endfunction

`endif

// File: verif/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
  import rv_pkg::*;

  `include "rv_asm.svh"

  // longest program plus reset, six tests
  localparam int timeout_cycles = 6 * 64;

  // branch table in the order beq bne blt bge bltu bgeu
  // forward pairs use x5 = 5, x6 = -3, x7 = 5, backward pairs use x1 counter, x2 = 2, x3 = 1
  localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam reg_addr_t  tk_a [6]  = '{5'd5, 5'd5, 5'd6, 5'd5, 5'd5, 5'd6};
  localparam reg_addr_t  tk_b [6]  = '{5'd7, 5'd6, 5'd5, 5'd6, 5'd6, 5'd5};
  localparam reg_addr_t  nt_a [6]  = '{5'd5, 5'd5, 5'd5, 5'd6, 5'd6, 5'd5};
  localparam reg_addr_t  nt_b [6]  = '{5'd6, 5'd7, 5'd6, 5'd5, 5'd5, 5'd6};
  localparam reg_addr_t  bk_a [6]  = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2};
  localparam reg_addr_t  bk_b [6]  = '{5'd3, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1};

  logic      clk;
  logic      rst;
  word_t     insn;
  word_t     pc;
  logic      halt;
  logic      illegal;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  word_t     prog [64];
  word_t     m_regs [32];
  word_t     m_pc;
  logic      m_halt;
  integer    seed = 32'hcc3a56e5;
  int        errors = 0;
  int        tests_failed = 0;
  int        test_start;
  int        cycles = 0;
  int        illegal_seen;
  int        x0_writes;
  int        p;

  always #5 clk = ~clk;

  rv_core_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .illegal (illegal),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  // combinational instruction memory, word addressed
  assign insn = prog[pc[7:2]];

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, the core did not reach halt", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic word_t rnd();
    return $random(seed);
  endfunction

  // integer result by funct3, alt picks sub and sra
  function automatic word_t int_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_val(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h at pc %h", name, got, exp, m_pc);
      errors++;
    end
  endtask

  // compare one cycle against the model, then commit it in the model
  task automatic check_step();
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      exp_data;
    word_t      next_pc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       exp_we;
    logic       exp_ill;
    logic       is_ecall;
    ins = prog[m_pc[7:2]];
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    exp_we = 1'b0;
    exp_ill = 1'b0;
    is_ecall = 1'b0;
    exp_data = '0;
    next_pc = m_pc + 32'd4;
    case (ins[6:0])
      7'h37: begin
        exp_we = 1'b1;
        exp_data = {ins[31:12], 12'd0};
      end
      7'h17: begin
        exp_we = 1'b1;
        exp_data = m_pc + {ins[31:12], 12'd0};
      end
      7'h13: begin
        // shift immediates need funct7 of 0, or 0x20 for srai
        exp_ill = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        exp_we = !exp_ill;
        exp_data = int_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, {{20{ins[31]}}, ins[31:20]});
      end
      7'h33: begin
        exp_ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        exp_we = !exp_ill;
        exp_data = int_ref(f3, f7 == 7'h20, a, b);
      end
      7'h63: begin
        exp_ill = (f3 == 3'd2 || f3 == 3'd3);
        if (!exp_ill && br_ref(f3, a, b)) begin
          next_pc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'h73: begin
        is_ecall = (ins[31:7] == 25'd0);
        exp_ill = !is_ecall;
        // the core parks on the ecall itself
        if (is_ecall) begin
          next_pc = m_pc;
        end
      end
      default: exp_ill = 1'b1;
    endcase
    // a halted core holds pc and retires nothing
    if (m_halt) begin
      exp_we = 1'b0;
      exp_ill = 1'b0;
      is_ecall = 1'b0;
      next_pc = m_pc;
    end
    check_val("pc", pc, m_pc);
    check_val("halt", {31'd0, halt}, {31'd0, m_halt});
    check_val("wb_en", {31'd0, wb_en}, {31'd0, exp_we});
    check_val("illegal", {31'd0, illegal}, {31'd0, exp_ill});
    if (exp_we && wb_en) begin
      check_val("wb_addr", {27'd0, wb_addr}, {27'd0, ins[11:7]});
      check_val("wb_data", wb_data, exp_data);
    end
    if (illegal) begin
      illegal_seen++;
    end
    if (wb_en && wb_addr == 5'd0) begin
      x0_writes++;
    end
    if (exp_we && ins[11:7] != 5'd0) begin
      m_regs[ins[11:7]] = exp_data;
    end
    m_pc = next_pc;
    if (is_ecall) begin
      m_halt = 1'b1;
    end
  endtask

  task automatic run_program();
    m_regs = '{default: '0};
    m_pc = '0;
    m_halt = 1'b0;
    @(posedge clk);
    #1 rst = 1'b1;
    @(posedge clk);
    // pc already sits on the first word, no write-back may show
    @(negedge clk);
    check_val("wb_en", {31'd0, wb_en}, 32'd0);
    @(posedge clk);
    #1 rst = 1'b0;
    do begin
      @(negedge clk);
      check_step();
    end while (!halt);
  endtask

  task automatic check_halted(input int n);
    repeat (n) begin
      @(negedge clk);
      check_step();
    end
  endtask

  task automatic new_program();
    // unused words hold lui x31 with their own index
    for (int i = 0; i < 64; i++) begin
      prog[i] = enc_u(op_lui, 5'd31, 20'(i));
    end
    p = 0;
    test_start = errors;
    illegal_seen = 0;
    x0_writes = 0;
  endtask

  task automatic emit(input word_t w);
    prog[p] = w;
    p++;
  endtask

  // upper part absorbs the sign of the low 12 bits
  task automatic load_const(input reg_addr_t rd, input word_t v);
    word_t up;
    up = v + 32'h800;
    emit(enc_u(op_lui, rd, up[31:12]));
    emit(enc_i(3'd0, rd, rd, v[11:0]));
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s: %0d mismatches", name, errors - test_start);
      tests_failed++;
    end
  endtask

  task automatic test_reg_imm();
    word_t     r;
    reg_addr_t src;
    new_program();
    load_const(5'd1, rnd());
    load_const(5'd2, rnd() | 32'h8000_0000);
    for (int k = 0; k < 2; k++) begin
      src = (k == 0) ? 5'd1 : 5'd2;
      for (int f = 0; f < 8; f++) begin
        r = rnd();
        if (f == 1 || f == 5) begin
          emit(enc_sh(7'h00, 3'(f), reg_addr_t'(8 + f + 8 * k), src, r[4:0]));
        end else begin
          emit(enc_i(3'(f), reg_addr_t'(8 + f + 8 * k), src, r[11:0]));
        end
      end
      r = rnd();
      emit(enc_sh(7'h20, 3'd5, reg_addr_t'(24 + k), src, r[4:0]));
    end
    emit(enc_i(3'd0, 5'd26, 5'd1, 12'hf9c));
    emit(enc_ecall());
    run_program();
    finish_test("reg_imm");
  endtask

  task automatic test_reg_reg();
    new_program();
    load_const(5'd1, rnd() & 32'h7fff_ffff);
    load_const(5'd2, rnd() | 32'h8000_0000);
    // bit 5 set, so the shift amount is above 31
    load_const(5'd3, rnd() | 32'h0000_0020);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 3'(f), reg_addr_t'(8 + f), 5'd1, 5'd2));
      emit(enc_r(7'h00, 3'(f), reg_addr_t'(16 + f), 5'd2, 5'd1));
      emit(enc_r(7'h00, 3'(f), reg_addr_t'(24 + f), 5'd2, 5'd3));
    end
    emit(enc_r(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
    emit(enc_r(7'h20, 3'd0, 5'd5, 5'd2, 5'd1));
    emit(enc_r(7'h20, 3'd5, 5'd6, 5'd2, 5'd3));
    emit(enc_r(7'h20, 3'd5, 5'd7, 5'd1, 5'd3));
    emit(enc_ecall());
    run_program();
    finish_test("reg_reg");
  endtask

  task automatic test_x0_auipc();
    word_t r;
    new_program();
    r = rnd();
    emit(enc_i(3'd0, 5'd0, 5'd0, 12'h5a5));
    load_const(5'd0, r);
    emit(enc_r(7'h00, 3'd0, 5'd1, 5'd0, 5'd0));
    emit(enc_u(op_auipc, 5'd2, r[19:0]));
    emit(enc_u(op_auipc, 5'd3, r[31:12]));
    emit(enc_r(7'h00, 3'd6, 5'd4, 5'd0, 5'd2));
    emit(enc_ecall());
    run_program();
    if (x0_writes != 3) begin
      $display("write-backs to x0 seen %0d times, expected 3", x0_writes);
      errors++;
    end
    finish_test("x0_and_auipc");
  endtask

  task automatic test_branches();
    new_program();
    emit(enc_i(3'd0, 5'd5, 5'd0, 12'd5));
    emit(enc_i(3'd0, 5'd6, 5'd0, 12'hffd));
    emit(enc_i(3'd0, 5'd7, 5'd0, 12'd5));
    emit(enc_i(3'd0, 5'd2, 5'd0, 12'd2));
    emit(enc_i(3'd0, 5'd3, 5'd0, 12'd1));
    for (int k = 0; k < 6; k++) begin
      // taken branch skips the x10 increment
      emit(enc_b(br_f3[k], tk_a[k], tk_b[k], 13'd8));
      emit(enc_i(3'd0, 5'd10, 5'd10, 12'd1));
      emit(enc_b(br_f3[k], nt_a[k], nt_b[k], 13'd8));
      emit(enc_i(3'd0, 5'd11, 5'd11, 12'd1));
      // loops back until the x1 counter flips the condition
      emit(enc_i(3'd0, 5'd1, 5'd0, 12'd0));
      emit(enc_i(3'd0, 5'd1, 5'd1, 12'd1));
      emit(enc_b(br_f3[k], bk_a[k], bk_b[k], 13'h1ffc));
    end
    emit(enc_ecall());
    run_program();
    finish_test("branches");
  endtask

  task automatic test_halt();
    new_program();
    emit(enc_i(3'd0, 5'd1, 5'd0, 12'd9));
    emit(enc_ecall());
    emit(enc_i(3'd0, 5'd2, 5'd0, 12'd3));
    run_program();
    // swap the word under the held pc, a writing op and then an illegal one
    prog[1] = enc_i(3'd0, 5'd2, 5'd0, 12'd3);
    check_halted(5);
    prog[1] = 32'h0012_345b;
    check_halted(5);
    finish_test("halt");
  endtask

  task automatic test_illegal();
    new_program();
    emit(enc_i(3'd0, 5'd1, 5'd0, 12'd7));
    // opcode 0x5b is not part of the subset
    emit(32'h0012_345b);
    emit(enc_r(7'h01, 3'd0, 5'd1, 5'd1, 5'd1));
    emit(enc_r(7'h00, 3'd0, 5'd2, 5'd1, 5'd0));
    emit(enc_ecall());
    run_program();
    if (illegal_seen != 2) begin
      $display("illegal raised on %0d instructions, expected 2", illegal_seen);
      errors++;
    end
    finish_test("illegal");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    test_reg_imm();
    test_reg_reg();
    test_x0_auipc();
    test_branches();
    test_halt();
    test_illegal();
    $display("%0d of 6 tests passed, %0d mismatches", 6 - tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
source/rv_pkg.sv
source/alu.sv
source/insn_decode.sv
source/pc_unit.sv
source/reg_file.sv
source/rv_core_top.sv
verif/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timescale 1ns/1ns -f files.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
